/* compile.f */
+incdir+src
src/pe_pkg.sv
src/inst_mem.sv
src/data_mem.sv
src/pe_control.sv
src/complex_alu.sv
src/pe.sv
testbench/pe_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the PE testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f compile.f \
    --top-module pe_tb \
    -o pe_sim

# Keep the simulation output for the result search
./obj_dir/pe_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation passed"

/* testbench/pe_tb.sv */
`default_nettype none

`include "pe_cfg.svh"

module pe_tb;
    import pe_pkg::*;

    localparam int dw = `PE_DATA_WIDTH;
    // Hang limit in clock cycles
    localparam int max_cycles = 2000;

    logic   clk;
    logic   reset;
    logic   din_v;
    cplx_t  din_ld;
    cplx_t  din_pe;
    logic   inst_v;
    inst_t  inst_in;
    logic   start;
    cplx_t  dout_pe;
    logic   dout_v;
    logic   done;

    integer seed;
    int     cycle;
    int     errors;
    int     checks;
    string  test_name;

    // Operand store as the program sees it, in issue order
    cplx_t  mirror [`PE_DMEM_DEPTH];
    cplx_t  exp_q [$];
    inst_t  prog_q [$];
    cplx_t  data_q [$];

    // Output timing of the current run
    int     out_count;
    int     first_out;
    int     last_out;

    pe dut (
        .clk     (clk),
        .reset   (reset),
        .din_v   (din_v),
        .din_ld  (din_ld),
        .din_pe  (din_pe),
        .inst_v  (inst_v),
        .inst_in (inst_in),
        .start   (start),
        .dout_pe (dout_pe),
        .dout_v  (dout_v),
        .done    (done)
    );

    always #20 clk = ~clk;

    // Cycle count and hang guard
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////
    // Reference model

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic cplx_t ref_add(cplx_t a, cplx_t b);
        component_t re;
        component_t im;
        re = a[2*dw-1:dw] + b[2*dw-1:dw];
        im = a[dw-1:0] + b[dw-1:0];
        return {re, im};
    endfunction

    function automatic cplx_t ref_sub(cplx_t a, cplx_t b);
        component_t re;
        component_t im;
        re = a[2*dw-1:dw] - b[2*dw-1:dw];
        im = a[dw-1:0] - b[dw-1:0];
        return {re, im};
    endfunction

    // Products summed wide, fraction dropped, low bits kept
    function automatic cplx_t ref_mul(cplx_t a, cplx_t b);
        longint ar;
        longint ai;
        longint br;
        longint bi;
        longint re_full;
        longint im_full;
        ar = longint'($signed(a[2*dw-1:dw]));
        ai = longint'($signed(a[dw-1:0]));
        br = longint'($signed(b[2*dw-1:dw]));
        bi = longint'($signed(b[dw-1:0]));
        re_full = (ar * br - ai * bi) >>> `PE_FRAC_BITS;
        im_full = (ar * bi + ai * br) >>> `PE_FRAC_BITS;
        return {re_full[dw-1:0], im_full[dw-1:0]};
    endfunction

    function automatic cplx_t expected_result(opcode_t op, cplx_t a, cplx_t b);
        case (op)
            op_add:  return ref_add(a, b);
            op_sub:  return ref_sub(a, b);
            default: return ref_mul(a, b);
        endcase
    endfunction

    function automatic opcode_t pick_arith(logic [1:0] sel);
        case (sel)
            2'd0:    return op_add;
            2'd1:    return op_sub;
            default: return op_mul;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    ////////////////////
    // Program and data building

    task automatic queue_data(input cplx_t value);
        mirror[addr_t'(data_q.size())] = value;
        data_q.push_back(value);
    endtask

    // Sequential model for programs with the four slot spacing
    task automatic add_inst(input opcode_t op, input logic wb, input addr_t src0,
                            input addr_t src1, input addr_t dst);
        cplx_t res;
        prog_q.push_back({op, wb, src0, src1, dst});
        if (op == op_movpe) begin
            mirror[dst] = din_pe;
        end else begin
            res = expected_result(op, mirror[src0], mirror[src1]);
            exp_q.push_back(res);
            if (wb) begin
                mirror[dst] = res;
            end
        end
    endtask

    task automatic load_data();
        foreach (data_q[i]) begin
            @(negedge clk);
            din_v  = 1'b1;
            din_ld = data_q[i];
        end
        @(negedge clk);
        din_v = 1'b0;
    endtask

    task automatic load_program();
        foreach (prog_q[i]) begin
            @(negedge clk);
            inst_v  = 1'b1;
            inst_in = prog_q[i];
        end
        @(negedge clk);
        inst_v = 1'b0;
    endtask

    // Programs here open with an arithmetic instruction
    task automatic run_program(input bit contiguous);
        int start_cycle;
        int len;
        int waited;
        len = prog_q.size();
        load_data();
        load_program();
        out_count = 0;
        @(negedge clk);
        start       = 1'b1;
        start_cycle = cycle;
        @(negedge clk);
        start  = 1'b0;
        waited = 0;
        while (!done && waited < len + 20) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            errors++;
            $display("No done pulse within %0d cycles of start in %s", len + 20, test_name);
        end else begin
            compare_value({test_name, " done cycle"}, start_cycle + 3 + len, cycle);
        end
        // Results may trail the done pulse
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s ended with %0d results never produced", test_name, exp_q.size());
            exp_q.delete();
        end
        if (out_count > 0) begin
            compare_value({test_name, " first result cycle"}, start_cycle + 4, first_out);
            if (contiguous) begin
                compare_value({test_name, " result span"}, out_count,
                              last_out - first_out + 1);
            end
        end
        prog_q.delete();
        data_q.delete();
    endtask

    ////////////////////
    // Result comparison

    always @(negedge clk) begin
        if (!reset && dout_v) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected dout_v with no result pending in %s", test_name);
            end else begin
                compare_value(test_name, exp_q.pop_front(), dout_pe);
            end
            if (out_count == 0) begin
                first_out = cycle;
            end
            last_out = cycle;
            out_count++;
        end
    end

    ////////////////////
    // Tests

    initial begin
        logic [31:0] r;
        clk       = 1'b0;
        reset     = 1'b1;
        din_v     = 1'b0;
        din_ld    = '0;
        din_pe    = '0;
        inst_v    = 1'b0;
        inst_in   = '0;
        start     = 1'b0;
        seed      = 32'hc9d39634;
        cycle     = 0;
        errors    = 0;
        checks    = 0;
        out_count = 0;
        first_out = 0;
        last_out  = 0;
        test_name = "reset";
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Quiet while idle, empty start ignored
        repeat (4) begin
            @(negedge clk);
            compare_value("reset done", 32'd0, 32'(done));
        end
        test_name = "empty_start";
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (8) begin
            @(negedge clk);
            compare_value("empty start done", 32'd0, 32'(done));
        end

        test_name = "add_sub";
        for (int i = 0; i < 8; i++) begin
            queue_data(next_random());
        end
        for (int i = 0; i < 10; i++) begin
            r = next_random();
            add_inst(pick_arith({1'b0, r[0]}), 1'b0, {1'b0, r[6:4]}, {1'b0, r[10:8]}, '0);
        end
        run_program(1'b1);

        // Negative and extreme components up front
        test_name = "multiply";
        queue_data({16'hff80, 16'h0100});
        queue_data({16'h8000, 16'hc000});
        queue_data({16'h7fff, 16'h8001});
        for (int i = 0; i < 5; i++) begin
            queue_data(next_random());
        end
        add_inst(op_mul, 1'b0, 4'd0, 4'd1, '0);
        add_inst(op_mul, 1'b0, 4'd2, 4'd2, '0);
        for (int i = 0; i < 6; i++) begin
            r = next_random();
            add_inst(op_mul, 1'b0, {1'b0, r[6:4]}, {1'b0, r[10:8]}, '0);
        end
        run_program(1'b1);

        // Rereads four slots on, moves to 15 as fillers
        test_name = "writeback_move";
        @(negedge clk);
        din_pe = next_random();
        for (int i = 0; i < 4; i++) begin
            queue_data(next_random());
        end
        add_inst(op_add,   1'b1, 4'd0, 4'd1, 4'd4);
        add_inst(op_mul,   1'b1, 4'd2, 4'd3, 4'd5);
        add_inst(op_movpe, 1'b0, 4'd0, 4'd0, 4'd6);
        add_inst(op_movpe, 1'b0, 4'd0, 4'd0, 4'd15);
        add_inst(op_sub,   1'b1, 4'd4, 4'd2, 4'd7);
        add_inst(op_mul,   1'b0, 4'd5, 4'd1, 4'd0);
        add_inst(op_add,   1'b1, 4'd6, 4'd0, 4'd8);
        add_inst(op_movpe, 1'b0, 4'd0, 4'd0, 4'd15);
        add_inst(op_add,   1'b0, 4'd7, 4'd7, 4'd0);
        add_inst(op_movpe, 1'b0, 4'd0, 4'd0, 4'd15);
        add_inst(op_sub,   1'b0, 4'd8, 4'd4, 4'd0);
        run_program(1'b0);

        // Full depth program, then a short rerun from address zero
        test_name = "full_depth";
        for (int i = 0; i < `PE_DMEM_DEPTH; i++) begin
            queue_data(next_random());
        end
        for (int i = 0; i < `PE_IMEM_DEPTH; i++) begin
            r = next_random();
            add_inst(pick_arith(r[1:0]), 1'b0, r[7:4], r[11:8], '0);
        end
        run_program(1'b1);

        test_name = "rerun";
        for (int i = 0; i < 3; i++) begin
            queue_data(next_random());
        end
        add_inst(op_add, 1'b0, 4'd0, 4'd1, '0);
        add_inst(op_mul, 1'b0, 4'd2, 4'd0, '0);
        add_inst(op_sub, 1'b0, 4'd1, 4'd2, '0);
        run_program(1'b1);

        repeat (4) @(negedge clk);
        $display("errors %0d checks %0d", errors, checks);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/pe.sv */
`default_nettype none

module pe (
    input  wire                clk,
    input  wire                reset,
    input  wire                din_v,
    input  wire pe_pkg::cplx_t din_ld,
    input  wire pe_pkg::cplx_t din_pe,
    input  wire                inst_v,
    input  wire pe_pkg::inst_t inst_in,
    input  wire                start,
    output wire pe_pkg::cplx_t dout_pe,
    output wire                dout_v,
    output wire                done
);
    import pe_pkg::*;

    // Fetch stage
    wire inst_t   fetch_inst;
    wire          issue_v;

    // Read stage
    wire addr_t   raddr0;
    wire addr_t   raddr1;
    wire cplx_t   rdata0;
    wire cplx_t   rdata1;
    wire opcode_t alu_op;
    wire          alu_op_v;

    // Writeback port
    wire          wr_en;
    wire addr_t   waddr;
    wire cplx_t   wdata;

    ////////////////////
    // Program store and sequencer

    inst_mem imem (
        .clk      (clk),
        .reset    (reset),
        .inst_v   (inst_v),
        .inst_in  (inst_in),
        .start    (start),
        .inst_out (fetch_inst),
        .issue_v  (issue_v),
        .done     (done)
    );

    ////////////////////
    // Operand store

    // Done rewinds the host load pointer
    data_mem dmem (
        .clk        (clk),
        .reset      (reset),
        .din_v      (din_v),
        .din_ld     (din_ld),
        .load_clear (done),
        .raddr0     (raddr0),
        .raddr1     (raddr1),
        .wr_en      (wr_en),
        .waddr      (waddr),
        .wdata      (wdata),
        .rdata0     (rdata0),
        .rdata1     (rdata1)
    );

    // Decoder and writeback select
    pe_control ctrl (
        .clk        (clk),
        .reset      (reset),
        .inst       (fetch_inst),
        .issue_v    (issue_v),
        .din_pe     (din_pe),
        .alu_result (dout_pe),
        .raddr0     (raddr0),
        .raddr1     (raddr1),
        .op         (alu_op),
        .op_v       (alu_op_v),
        .wr_en      (wr_en),
        .waddr      (waddr),
        .wdata      (wdata)
    );

    // Complex arithmetic
    complex_alu alu (
        .clk    (clk),
        .reset  (reset),
        .op     (alu_op),
        .op_v   (alu_op_v),
        .din_1  (rdata0),
        .din_2  (rdata1),
        .dout   (dout_pe),
        .dout_v (dout_v)
    );

endmodule

`default_nettype wire

/* src/complex_alu.sv */
`default_nettype none

`include "pe_cfg.svh"

module complex_alu (
    input  wire                  clk,
    input  wire                  reset,
    input  wire pe_pkg::opcode_t op,
    input  wire                  op_v,
    input  wire pe_pkg::cplx_t   din_1,
    input  wire pe_pkg::cplx_t   din_2,
    output pe_pkg::cplx_t        dout,
    output logic                 dout_v
);
    import pe_pkg::*;

    localparam int dw = `PE_DATA_WIDTH;

    // Operand halves
    component_t a_re;
    component_t a_im;
    component_t b_re;
    component_t b_im;

    // Partial products at double width
    logic signed [2*dw-1:0] p_rr;
    logic signed [2*dw-1:0] p_ii;
    logic signed [2*dw-1:0] p_ri;
    logic signed [2*dw-1:0] p_ir;
    logic signed [2*dw-1:0] mul_re_full;
    logic signed [2*dw-1:0] mul_im_full;
    logic signed [2*dw-1:0] mul_re_shr;
    logic signed [2*dw-1:0] mul_im_shr;

    cplx_t result;
    logic  do_result;

    assign a_re = din_1[2*dw-1:dw];
    assign a_im = din_1[dw-1:0];
    assign b_re = din_2[2*dw-1:dw];
    assign b_im = din_2[dw-1:0];

    ////////////////////
    // Multiply path

    assign p_rr = $signed(a_re) * $signed(b_re);
    assign p_ii = $signed(a_im) * $signed(b_im);
    assign p_ri = $signed(a_re) * $signed(b_im);
    assign p_ir = $signed(a_im) * $signed(b_re);

    // Sums wrap at double width
    assign mul_re_full = p_rr - p_ii;
    assign mul_im_full = p_ri + p_ir;

    // Drop the fraction and keep the low component bits
    assign mul_re_shr = mul_re_full >>> `PE_FRAC_BITS;
    assign mul_im_shr = mul_im_full >>> `PE_FRAC_BITS;

    ////////////////////
    // Result select

    always_comb begin
        case (op)
            op_add:  result = {a_re + b_re, a_im + b_im};
            op_sub:  result = {a_re - b_re, a_im - b_im};
            op_mul:  result = {mul_re_shr[dw-1:0], mul_im_shr[dw-1:0]};
            // Move has no arithmetic result
            default: result = '0;
        endcase
    end

    assign do_result = op_v && (op != op_movpe);

    always_ff @(posedge clk) begin
        if (reset) begin
            dout_v <= 1'b0;
        end else begin
            dout_v <= do_result;
        end
    end

    // Output word held between results
    always_ff @(posedge clk) begin
        if (do_result) begin
            dout <= result;
        end
    end

    // Output strobe settles once reset is gone
    a_dout_v_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(dout_v));

endmodule

`default_nettype wire

/* src/pe_control.sv */
`default_nettype none

module pe_control (
    input  wire                clk,
    input  wire                reset,
    input  wire pe_pkg::inst_t inst,
    input  wire                issue_v,
    input  wire pe_pkg::cplx_t din_pe,
    input  wire pe_pkg::cplx_t alu_result,
    output pe_pkg::addr_t      raddr0,
    output pe_pkg::addr_t      raddr1,
    output pe_pkg::opcode_t    op,
    output logic               op_v,
    output logic               wr_en,
    output pe_pkg::addr_t      waddr,
    output pe_pkg::cplx_t      wdata
);
    import pe_pkg::*;

    // Decoded fields of the fetched word
    opcode_t dec_op;
    logic    dec_wb;
    logic    dec_move;
    addr_t   dec_dst;

    // Read stage, aligned with the operands
    addr_t   dst_rd;
    logic    wb_rd;
    logic    mv_rd;

    // Execute stage, aligned with the ALU result
    addr_t   dst_ex;
    logic    wb_ex;
    logic    mv_ex;

    ////////////////////
    // Decode

    assign dec_op   = opcode_t'(inst[op_msb:op_lsb]);
    assign dec_wb   = inst[wb_bit];
    assign dec_move = (dec_op == op_movpe);
    assign dec_dst  = inst[dst_msb:dst_lsb];

    // Read addresses go straight to the operand store
    assign raddr0 = inst[src0_msb:src0_lsb];
    assign raddr1 = inst[src1_msb:src1_lsb];

    ////////////////////
    // Pipe stages

    always_ff @(posedge clk) begin
        if (reset) begin
            op_v  <= 1'b0;
            wb_rd <= 1'b0;
            mv_rd <= 1'b0;
            wb_ex <= 1'b0;
            mv_ex <= 1'b0;
        end else begin
            op_v  <= issue_v;
            // Writeback flag only counts for arithmetic
            wb_rd <= issue_v && dec_wb && !dec_move;
            mv_rd <= issue_v && dec_move;
            wb_ex <= wb_rd;
            mv_ex <= mv_rd;
        end
    end

    // Opcode and destinations qualified by the flags above
    always_ff @(posedge clk) begin
        op     <= dec_op;
        dst_rd <= dec_dst;
        dst_ex <= dst_rd;
    end

    // Execute stage write select
    assign wr_en = wb_ex || mv_ex;
    assign waddr = dst_ex;
    assign wdata = mv_ex ? din_pe : alu_result;

endmodule

`default_nettype wire

/* src/data_mem.sv */
`default_nettype none

`include "pe_cfg.svh"

module data_mem (
    input  wire                clk,
    input  wire                reset,
    input  wire                din_v,
    input  wire pe_pkg::cplx_t din_ld,
    input  wire                load_clear,
    input  wire pe_pkg::addr_t raddr0,
    input  wire pe_pkg::addr_t raddr1,
    input  wire                wr_en,
    input  wire pe_pkg::addr_t waddr,
    input  wire pe_pkg::cplx_t wdata,
    output pe_pkg::cplx_t      rdata0,
    output pe_pkg::cplx_t      rdata1
);
    import pe_pkg::*;

    // Complex operands
    cplx_t mem [`PE_DMEM_DEPTH];

    addr_t load_ptr;
    logic  host_we;

    // Single write port shared by host and writeback
    logic  mem_we;
    addr_t mem_waddr;
    cplx_t mem_wdata;

    // Writeback wins the port
    assign host_we = din_v && !wr_en && !load_clear;

    assign mem_we    = wr_en || host_we;
    assign mem_waddr = wr_en ? waddr : load_ptr;
    assign mem_wdata = wr_en ? wdata : din_ld;

    ////////////////////
    // Host load pointer

    always_ff @(posedge clk) begin
        if (reset || load_clear) begin
            load_ptr <= '0;
        end else if (host_we) begin
            load_ptr <= load_ptr + addr_t'(1);
        end
    end

    ////////////////////
    // Array access

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // Read before write on the same address
    always_ff @(posedge clk) begin
        rdata0 <= mem[raddr0];
        rdata1 <= mem[raddr1];
    end

    // Host loads stay out of a running program
    a_no_load_on_wb: assert property (@(posedge clk) disable iff (reset)
        !(din_v && wr_en));

endmodule

`default_nettype wire

/* src/inst_mem.sv */
`default_nettype none

`include "pe_cfg.svh"

module inst_mem (
    input  wire                clk,
    input  wire                reset,
    input  wire                inst_v,
    input  wire pe_pkg::inst_t inst_in,
    input  wire                start,
    output pe_pkg::inst_t      inst_out,
    output logic               issue_v,
    output logic               done
);
    import pe_pkg::*;

    // Program words
    inst_t      prog [`PE_IMEM_DEPTH];

    pc_t        load_ptr;
    pc_t        prog_len;
    pc_t        pc;
    seq_state_t state;

    logic       load_ok;
    logic       last_issue;
    // Tail of the run after the last issue
    logic       drain_1;
    logic       drain_2;
    logic       idle;

    // Idle also waits out the drain and the done cycle
    assign idle = (state == seq_idle) && !drain_1 && !drain_2 && !done;

    assign load_ok = inst_v && idle && (load_ptr < pc_t'(`PE_IMEM_DEPTH));

    assign last_issue = (state == seq_run) && ((pc + pc_t'(1)) == prog_len);

    ////////////////////
    // Host program load

    always_ff @(posedge clk) begin
        if (reset || done) begin
            load_ptr <= '0;
        end else if (load_ok) begin
            load_ptr <= load_ptr + pc_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok) begin
            prog[load_ptr[`PE_ADDR_WIDTH-1:0]] <= inst_in;
        end
    end

    ////////////////////
    // Run sequencer

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= seq_idle;
            pc       <= '0;
            prog_len <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    // Empty program is ignored
                    if (start && idle && (load_ptr != '0)) begin
                        prog_len <= load_ptr;
                        pc       <= '0;
                        state    <= seq_run;
                    end
                end
                seq_run: begin
                    pc <= pc + pc_t'(1);
                    if (last_issue) begin
                        state <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // Registered fetch of the issuing word
    always_ff @(posedge clk) begin
        inst_out <= prog[pc[`PE_ADDR_WIDTH-1:0]];
    end

    // Issue strobe and done two stages past the last fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_v <= 1'b0;
            drain_1 <= 1'b0;
            drain_2 <= 1'b0;
            done    <= 1'b0;
        end else begin
            issue_v <= (state == seq_run);
            drain_1 <= last_issue;
            drain_2 <= drain_1;
            done    <= drain_2;
        end
    end

    // Counter never runs past the latched length
    a_pc_in_range: assert property (@(posedge clk) disable iff (reset)
        (state == seq_run) |-> (pc < prog_len));

    // No restart while a program is issuing
    a_no_start_in_run: assert property (@(posedge clk) disable iff (reset)
        (state == seq_run) |-> !start);

endmodule

`default_nettype wire

/* src/pe_pkg.sv */
`default_nettype none

`include "pe_cfg.svh"

package pe_pkg;

    ////////////////////
    // Data words

    // One component in two's complement
    typedef logic [`PE_DATA_WIDTH-1:0] component_t;
    // Real part on top, imaginary below
    typedef logic [2*`PE_DATA_WIDTH-1:0] cplx_t;
    typedef logic [`PE_ADDR_WIDTH-1:0] addr_t;
    // One extra bit so a full program length fits
    typedef logic [`PE_ADDR_WIDTH:0] pc_t;

    ////////////////////
    // Instruction format

    typedef enum logic [1:0] {
        op_add   = 2'b00,
        op_sub   = 2'b01,
        op_mul   = 2'b10,
        op_movpe = 2'b11
    } opcode_t;

    // Opcode, writeback flag, then three addresses
    localparam int inst_width = 3 + 3 * `PE_ADDR_WIDTH;
    typedef logic [inst_width-1:0] inst_t;

    // Field positions from the top down
    localparam int op_msb   = inst_width - 1;
    localparam int op_lsb   = inst_width - 2;
    localparam int wb_bit   = inst_width - 3;
    localparam int src0_msb = 3 * `PE_ADDR_WIDTH - 1;
    localparam int src0_lsb = 2 * `PE_ADDR_WIDTH;
    localparam int src1_msb = 2 * `PE_ADDR_WIDTH - 1;
    localparam int src1_lsb = `PE_ADDR_WIDTH;
    localparam int dst_msb  = `PE_ADDR_WIDTH - 1;
    localparam int dst_lsb  = 0;

    // Run sequencer
    typedef enum logic {seq_idle, seq_run} seq_state_t;

endpackage

`default_nettype wire

/* src/pe_cfg.svh */
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// Width of one real or imaginary component
`define PE_DATA_WIDTH 16

// Fixed point scaling of products
`define PE_FRAC_BITS 8

// Operand store entries
`define PE_DMEM_DEPTH 16

// Program store entries
`define PE_IMEM_DEPTH 16

// Address bits shared by both stores
`define PE_ADDR_WIDTH 4

`endif
